// ==== hdl/sprite_pkg.sv ====
package sprite_pkg;

    // --------------------------------------------------------------------
    // Fixed-point format
    // --------------------------------------------------------------------
    localparam int INT_BITS  = 12;                   // Pixel part
    localparam int FRAC_BITS = 24;                   // Sub-pixel part
    localparam int FX_BITS   = INT_BITS + FRAC_BITS; // Q12.24 total

    typedef logic [INT_BITS-1:0] pos_t;    // Pixel coordinate
    typedef logic [FX_BITS-1:0]  pos_fx_t; // Integer part sits in the top 12 bits
    typedef logic [3:0]          photo_t;

    localparam int NUM_SPRITES_MAX = 8;
    typedef logic [$clog2(NUM_SPRITES_MAX)-1:0] sprite_id_t;

    typedef enum logic [2:0] {
        IDLE,
        WALK,
        SNIFF,
        JUMP,
        FALL
    } motion_state_t;

    localparam pos_t HOME_Y = 12'd595; // Ground row shared by every sprite

    // Routine thresholds in pixels
    localparam pos_t WALK_END_X  = 12'd650; // Walk while x >= this
    localparam pos_t SNIFF_END_X = 12'd653; // Sniff while x < this
    localparam pos_t JUMP_TOP_Y  = 12'd450; // Rise while y > this
    localparam pos_t FALL_END_Y  = 12'd600; // Drop while y < this

    // Step sizes in Q12.24 LSBs, sign applied by the engine
    localparam pos_fx_t WALK_DX  = 36'd26; // Left
    localparam pos_fx_t SNIFF_DX = 36'd1;  // Right
    localparam pos_fx_t JUMP_DX  = 36'd20; // Left
    localparam pos_fx_t JUMP_DY  = 36'd70; // Up
    localparam pos_fx_t FALL_DX  = 36'd20; // Left
    localparam pos_fx_t FALL_DY  = 36'd50; // Down

    // Photo indices, walk cycles through 0..WALK_FRAMES-1
    localparam int     WALK_FRAMES = 6;
    localparam photo_t PHOTO_HOME  = 4'd0;
    localparam photo_t PHOTO_SNIFF = 4'd6;
    localparam photo_t PHOTO_JUMP  = 4'd7;
    localparam photo_t PHOTO_FALL  = 4'd8;

    typedef struct packed {
        pos_t   xpos;
        pos_t   ypos;
        photo_t photo;
    } sprite_report_t;

endpackage

// ==== hdl/sprite_report_if.sv ====
`timescale 1ns/1ps

// Four-phase report link from one motion engine to the collector
interface sprite_report_if;
    import sprite_pkg::*;

    logic           req;     // Raised by the engine with a fresh report
    logic           ack;     // Raised by the collector once the record is taken
    sprite_report_t payload; // Held from req rise until ack falls

    // Engine side owns req and the payload
    modport engine (
        output req,
        output payload,
        input  ack
    );

    // Collector side only answers
    modport collector (
        input  req,
        input  payload,
        output ack
    );

endinterface

// ==== hdl/frame_dispatcher.sv ====
`timescale 1ns/1ps

module frame_dispatcher #(
    parameter int NUM_SPRITES = 2
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   frame_tick, // One pulse per video frame
    output logic [NUM_SPRITES-1:0] step_req,   // Doubles as the still-to-lower mask
    input  logic [NUM_SPRITES-1:0] step_ack
);

    // --------------------------------------------------------------------
    // Sequencer state
    // --------------------------------------------------------------------
    typedef enum logic {
        D_IDLE,
        D_STEP
    } disp_state_t;

    disp_state_t state;
    logic        step_done; // Every req lowered and every ack back low

    assign step_done = (step_req == '0) && (step_ack == '0);

    // --------------------------------------------------------------------
    // Four-phase request generation
    // --------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= D_IDLE;
            step_req <= '0;
        end else begin
            case (state)
                D_IDLE: begin
                    // A tick starts a step for all engines at once
                    if (frame_tick) begin
                        step_req <= '1;
                        state    <= D_STEP;
                    end
                end
                D_STEP: begin
                    // Drop each req as soon as its own ack shows up
                    step_req <= step_req & ~step_ack;
                    if (step_done) begin
                        state <= D_IDLE; // Ticks seen in D_STEP are simply lost
                    end
                end
                default: begin
                    state    <= D_IDLE;
                    step_req <= '0;
                end
            endcase
        end
    end

endmodule

// ==== hdl/sprite_motion_engine.sv ====
`timescale 1ns/1ps

module sprite_motion_engine #(
    parameter sprite_pkg::pos_t START_X = 12'd1024 // Home column of this sprite
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            game_enable, // Looked at only when a step starts
    input  logic            step_req,
    output logic            step_ack,
    sprite_report_if.engine rpt
);
    import sprite_pkg::*;

    // Home position in Q12.24
    localparam pos_fx_t HOME_X_FX = {START_X, {FRAC_BITS{1'b0}}};
    localparam pos_fx_t HOME_Y_FX = {HOME_Y, {FRAC_BITS{1'b0}}};

    motion_state_t state, state_nxt;
    pos_fx_t       x_fx, y_fx;         // Full-precision position
    pos_fx_t       x_fx_nxt, y_fx_nxt;
    pos_t          x_pix, y_pix;       // Integer pixel view
    pos_t          walk_sel;           // Walk frame before narrowing
    photo_t        photo, photo_nxt;
    logic          step_busy;          // Step taken, ack phases not finished
    logic          rpt_pending;        // Last report still in its four phases
    logic          step_start;

    assign x_pix = x_fx[FX_BITS-1:FRAC_BITS];
    assign y_pix = y_fx[FX_BITS-1:FRAC_BITS];

    // Back-pressure from the collector stalls the next step here
    assign step_start = step_req && !step_busy && !rpt_pending;

    // --------------------------------------------------------------------
    // Routine next state
    // --------------------------------------------------------------------
    always_comb begin
        case (state)
            IDLE:    state_nxt = game_enable ? WALK : IDLE;
            WALK:    state_nxt = (x_pix >= WALK_END_X) ? WALK : SNIFF;
            SNIFF:   state_nxt = (x_pix < SNIFF_END_X) ? SNIFF : JUMP;
            JUMP:    state_nxt = (y_pix > JUMP_TOP_Y) ? JUMP : FALL;
            FALL:    state_nxt = (y_pix < FALL_END_Y) ? FALL : IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    // --------------------------------------------------------------------
    // Position step and photo, chosen by the new state
    // --------------------------------------------------------------------
    always_comb begin
        walk_sel = (x_pix >> 4) % pos_t'(WALK_FRAMES); // Pre-step column picks the frame
        case (state_nxt)
            IDLE: begin
                x_fx_nxt  = HOME_X_FX; // Back home
                y_fx_nxt  = HOME_Y_FX;
                photo_nxt = PHOTO_HOME;
            end
            WALK: begin
                x_fx_nxt  = x_fx - WALK_DX;
                y_fx_nxt  = y_fx;
                photo_nxt = walk_sel[3:0];
            end
            SNIFF: begin
                x_fx_nxt  = x_fx + SNIFF_DX; // Creep forward a hair
                y_fx_nxt  = y_fx;
                photo_nxt = PHOTO_SNIFF;
            end
            JUMP: begin
                x_fx_nxt  = x_fx - JUMP_DX;
                y_fx_nxt  = y_fx - JUMP_DY; // Screen y grows downward
                photo_nxt = PHOTO_JUMP;
            end
            FALL: begin
                x_fx_nxt  = x_fx - FALL_DX;
                y_fx_nxt  = y_fx + FALL_DY;
                photo_nxt = PHOTO_FALL;
            end
            default: begin
                x_fx_nxt  = x_fx;
                y_fx_nxt  = y_fx;
                photo_nxt = photo;
            end
        endcase
    end

    // Motion registers move once per accepted step
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            x_fx  <= HOME_X_FX;
            y_fx  <= HOME_Y_FX;
            photo <= PHOTO_HOME;
        end else if (step_start) begin
            state <= state_nxt;
            x_fx  <= x_fx_nxt;
            y_fx  <= y_fx_nxt;
            photo <= photo_nxt;
        end
    end

    // --------------------------------------------------------------------
    // Step handshake toward the dispatcher
    // --------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            step_busy <= 1'b0;
            step_ack  <= 1'b0;
        end else begin
            if (step_start) begin
                step_busy <= 1'b1;
            end else if (step_busy && step_req && !step_ack) begin
                step_ack <= 1'b1;  // One cycle after the new position lands
            end else if (step_ack && !step_req) begin
                step_ack  <= 1'b0; // Last phase, ready for the next frame
                step_busy <= 1'b0;
            end
        end
    end

    // --------------------------------------------------------------------
    // Report handshake toward the collector
    // --------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            rpt.req     <= 1'b0;
            rpt_pending <= 1'b0;
        end else begin
            if (step_start) begin
                rpt.req     <= 1'b1; // Same edge as the position update
                rpt_pending <= 1'b1;
            end else if (rpt.req && rpt.ack) begin
                rpt.req <= 1'b0;
            end else if (rpt_pending && !rpt.req && !rpt.ack) begin
                rpt_pending <= 1'b0;
            end
        end
    end

    // Registers only change on a step start, so the payload holds while pending
    assign rpt.payload = '{xpos: x_pix, ypos: y_pix, photo: photo};

endmodule

// ==== hdl/report_collector.sv ====
`timescale 1ns/1ps

module report_collector #(
    parameter int NUM_SPRITES = 2
) (
    input  logic                      clk,
    input  logic                      rst,
    sprite_report_if.collector        rpt [NUM_SPRITES],
    output logic                      out_valid,
    input  logic                      out_ready,
    output sprite_pkg::sprite_id_t    out_id,
    output sprite_pkg::pos_t          out_xpos,
    output sprite_pkg::pos_t          out_ypos,
    output sprite_pkg::photo_t        out_photo
);
    import sprite_pkg::*;

    localparam sprite_id_t LAST_ID = sprite_id_t'(NUM_SPRITES - 1);

    typedef enum logic [1:0] {
        C_WAIT, // Waiting for the selected engine's req
        C_SHOW, // Record on the output, out_valid high
        C_ACK   // Ack high until the engine drops req
    } coll_state_t;

    coll_state_t            state;
    sprite_id_t             ptr;         // Round-robin pointer
    logic [NUM_SPRITES-1:0] sel;         // One-hot form of ptr
    logic [NUM_SPRITES-1:0] req_vec;
    logic [NUM_SPRITES-1:0] ack_vec;
    sprite_report_t         payload_arr [NUM_SPRITES];
    sprite_report_t         cur_rpt;
    logic                   cur_req;

    // Flatten the interface array so it can be muxed by ptr
    for (genvar g = 0; g < NUM_SPRITES; g++) begin : g_link
        assign req_vec[g]     = rpt[g].req;
        assign payload_arr[g] = rpt[g].payload;
        assign rpt[g].ack     = ack_vec[g];
    end

    always_comb begin
        cur_rpt = '0;
        for (int i = 0; i < NUM_SPRITES; i++) begin
            sel[i] = (ptr == sprite_id_t'(i));
            if (sel[i]) begin
                cur_rpt = payload_arr[i];
            end
        end
    end

    assign cur_req   = |(req_vec & sel);
    assign out_valid = (state == C_SHOW);

    // --------------------------------------------------------------------
    // Pointer and handshake control
    // --------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= C_WAIT;
            ptr     <= '0;
            ack_vec <= '0;
        end else begin
            case (state)
                C_WAIT: if (cur_req) state <= C_SHOW;
                C_SHOW: begin
                    if (out_ready) begin // Record taken downstream
                        ack_vec <= sel;
                        state   <= C_ACK;
                    end
                end
                C_ACK: begin
                    if (!cur_req) begin
                        ack_vec <= '0;
                        ptr     <= (ptr == LAST_ID) ? '0 : ptr + 1'b1;
                        state   <= C_WAIT;
                    end
                end
                default: state <= C_WAIT;
            endcase
        end
    end

    // Output record, loaded once and held through stalls
    always_ff @(posedge clk) begin
        if (state == C_WAIT && cur_req) begin
            out_id    <= ptr;
            out_xpos  <= cur_rpt.xpos;
            out_ypos  <= cur_rpt.ypos;
            out_photo <= cur_rpt.photo;
        end
    end

endmodule

// ==== hdl/sprite_anim_top.sv ====
`timescale 1ns/1ps

module sprite_anim_top #(
    parameter int NUM_SPRITES = 2
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   game_enable,
    input  logic                   frame_tick,
    input  logic                   out_ready,
    output logic                   out_valid,
    output sprite_pkg::sprite_id_t out_id,
    output sprite_pkg::pos_t       out_xpos,
    output sprite_pkg::pos_t       out_ypos,
    output sprite_pkg::photo_t     out_photo
);
    import sprite_pkg::*;

    logic [NUM_SPRITES-1:0] step_req; // Dispatcher to engines
    logic [NUM_SPRITES-1:0] step_ack; // One bit back from each engine

    sprite_report_if rpt_if [NUM_SPRITES] ();

    // --------------------------------------------------------------------
    // Feeder
    // --------------------------------------------------------------------
    frame_dispatcher #(
        .NUM_SPRITES (NUM_SPRITES)
    ) u_dispatcher (
        .clk        (clk),
        .rst        (rst),
        .frame_tick (frame_tick),
        .step_req   (step_req),
        .step_ack   (step_ack)
    );

    // Engines start 64 pixels apart from the right edge
    for (genvar g = 0; g < NUM_SPRITES; g++) begin : g_engine
        localparam pos_t START_X_G = pos_t'(1024 - 64 * g);

        sprite_motion_engine #(
            .START_X (START_X_G)
        ) u_engine (
            .clk         (clk),
            .rst         (rst),
            .game_enable (game_enable),
            .step_req    (step_req[g]),
            .step_ack    (step_ack[g]),
            .rpt         (rpt_if[g])
        );
    end

    // Drain in sprite order
    report_collector #(
        .NUM_SPRITES (NUM_SPRITES)
    ) u_collector (
        .clk       (clk),
        .rst       (rst),
        .rpt       (rpt_if),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_id    (out_id),
        .out_xpos  (out_xpos),
        .out_ypos  (out_ypos),
        .out_photo (out_photo)
    );

endmodule

// ==== verification/sprite_anim_tb.sv ====
`timescale 1ns/1ps

module sprite_anim_tb;
    import sprite_pkg::*;

    localparam int NUM_SPRITES  = 2;
    localparam int WAIT_LIMIT   = 400; // Cycles allowed for any one wait
    localparam int QUIET_CYCLES = 24;  // Idle run that marks the end of a frame

    typedef struct packed {
        sprite_id_t id;
        pos_t       x;
        pos_t       y;
        photo_t     photo;
    } rec_t;

    logic       clk = 1'b0;
    logic       rst;
    logic       game_enable;
    logic       frame_tick;
    logic       out_ready;
    logic       out_valid;
    sprite_id_t out_id;
    pos_t       out_xpos;
    pos_t       out_ypos;
    photo_t     out_photo;

    rec_t rec_q [$];     // Accepted records still waiting for a match
    int   rec_cnt = 0;   // Records since the last count check
    logic hold_pending;  // Valid was stalled on the previous edge
    rec_t held;          // Record shown on that edge

    always #20 clk = ~clk; // 40 ns period

    sprite_anim_top #(
        .NUM_SPRITES (NUM_SPRITES)
    ) u_dut (
        .clk         (clk),
        .rst         (rst),
        .game_enable (game_enable),
        .frame_tick  (frame_tick),
        .out_ready   (out_ready),
        .out_valid   (out_valid),
        .out_id      (out_id),
        .out_xpos    (out_xpos),
        .out_ypos    (out_ypos),
        .out_photo   (out_photo)
    );

    // ------------------------------------------------------------------
    // Failure handling and compares
    // ------------------------------------------------------------------
    task automatic stop_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "testbench stopped on the first error");
    endtask

    task automatic check_report(input string what,
                                input sprite_id_t got_id, input pos_t got_x,
                                input pos_t got_y, input photo_t got_photo,
                                input sprite_id_t exp_id, input pos_t exp_x,
                                input pos_t exp_y, input photo_t exp_photo);
        string got_s;
        string exp_s;
        got_s = $sformatf("id %0d (%0d,%0d) photo %0d", got_id, got_x, got_y, got_photo);
        exp_s = $sformatf("id %0d (%0d,%0d) photo %0d", exp_id, exp_x, exp_y, exp_photo);
        if (got_id !== exp_id || got_x !== exp_x || got_y !== exp_y
                || got_photo !== exp_photo) begin
            stop_run($sformatf("[FAIL] %0t: %s, got %s, expected %s",
                               $time, what, got_s, exp_s));
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            stop_run($sformatf("[FAIL] %0t: %s, got %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic check_valid(input string what, input logic got);
        if (got !== 1'b1) begin
            stop_run($sformatf("[FAIL] %0t: %s", $time, what));
        end
    endtask

    // ------------------------------------------------------------------
    // Output monitor sampling on the same edge as the collector
    // ------------------------------------------------------------------
    always @(posedge clk) begin
        if (!rst && hold_pending) begin // Stalled record must stay put
            check_valid("out_valid dropped while out_ready was low", out_valid);
            check_report("record changed during a stall", out_id, out_xpos, out_ypos,
                         out_photo, held.id, held.x, held.y, held.photo);
        end
        if (!rst && out_valid && out_ready) begin
            rec_q.push_back('{id: out_id, x: out_xpos, y: out_ypos, photo: out_photo});
            rec_cnt++;
        end
        hold_pending <= !rst && out_valid && !out_ready;
        held         <= '{id: out_id, x: out_xpos, y: out_ypos, photo: out_photo};
    end

    // ------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------
    task automatic apply_reset();
        rst <= 1'b1;
        repeat (8) @(posedge clk); // 8 cycles of reset
        rst <= 1'b0;
    endtask

    task automatic pulse_tick();
        @(posedge clk);
        frame_tick <= 1'b1;
        @(posedge clk);
        frame_tick <= 1'b0; // Seen high for exactly one edge
    endtask

    task automatic take_record(input int id, input int x, input int y, input int photo);
        rec_t r;
        int   t;
        t = 0;
        while (rec_q.size() == 0) begin
            if (t == WAIT_LIMIT) begin
                stop_run("timed out waiting for an output record");
            end else begin
                t++;
                @(posedge clk);
            end
        end
        r = rec_q.pop_front();
        check_report("output record", r.id, r.x, r.y, r.photo,
                     sprite_id_t'(id), pos_t'(x), pos_t'(y), photo_t'(photo));
    endtask

    // Frame is over once out_valid stays low for a while
    task automatic wait_quiet();
        int quiet;
        int t;
        quiet = 0;
        t     = 0;
        while (quiet < QUIET_CYCLES) begin
            if (t == WAIT_LIMIT) begin
                stop_run("timed out waiting for the output port to go quiet");
            end else begin
                @(posedge clk);
                t++;
                quiet = out_valid ? 0 : quiet + 1;
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Command loop over the test file
    // ------------------------------------------------------------------
    initial begin : run_tests
        int    fd;
        int    v0, v1, v2, v3;
        string line;
        byte   cmd;
        rst         <= 1'b1;
        game_enable <= 1'b0;
        frame_tick  <= 1'b0;
        out_ready   <= 1'b1;
        apply_reset();
        fd = $fopen("verification/sprite_anim_tests.txt", "r");
        if (fd == 0) begin
            stop_run("could not open verification/sprite_anim_tests.txt");
        end
        while ($fgets(line, fd) != 0) begin
            cmd = line.getc(0);
            void'($sscanf(line.substr(1, line.len() - 1), "%d %d %d %d", v0, v1, v2, v3));
            case (cmd)
                "E": begin
                    @(posedge clk);
                    game_enable <= (v0 != 0);
                end
                "R": begin
                    @(posedge clk);
                    out_ready <= (v0 != 0); // Level held until the next R
                end
                "T": pulse_tick();
                "W": repeat (v0) @(posedge clk);
                "Z": apply_reset();
                "X": take_record(v0, v1, v2, v3);
                "C": begin
                    wait_quiet();
                    check_count("records in frame", rec_cnt, v0);
                    check_count("records left unmatched", rec_q.size(), 0);
                    rec_cnt = 0;
                end
                "#", "\n", "\r", " ": begin
                end
                default: stop_run($sformatf("unknown command in test file: %s", line));
            endcase
        end
        $fclose(fd);
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== verification/sprite_anim_tests.txt ====
# Commands: E level | R level | T | W cycles | Z | X id x y photo | C count
# X is one expected record in decimal, C the record total since the last C
R 1
E 0
# Disabled sprites stay at home
T
X 0 1024 595 0
X 1 960 595 0
C 2
# First walk step, photo from the home column
E 1
T
X 0 1023 595 4
X 1 959 595 0
C 2
# Sub-pixel steps keep the pixel column
T
X 0 1023 595 3
X 1 959 595 5
C 2
# Walking carries on with enable low
E 0
T
X 0 1023 595 3
X 1 959 595 5
C 2
# Ready held low, second tick lands inside the step and is dropped
R 0
T
W 1
T
W 20
R 1
X 0 1023 595 3
X 1 959 595 5
C 2
# Reset brings both sprites home
Z
T
X 0 1024 595 0
X 1 960 595 0
C 2

// ==== build.f ====
hdl/sprite_pkg.sv
hdl/sprite_report_if.sv
hdl/frame_dispatcher.sv
hdl/sprite_motion_engine.sv
hdl/report_collector.sv
hdl/sprite_anim_top.sv
verification/sprite_anim_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the testbench with Verilator; the exit status is the result
cd "$(dirname "$0")" &&
    verilator --binary --timing --top-module sprite_anim_tb -f build.f &&
    ./obj_dir/Vsprite_anim_tb ||
    { echo "sprite_anim simulation failed"; exit 1; }
